/* design/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  mipsPkg::aluOp_e op,
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  logic [4:0]      shamt,
    output logic [31:0]     y
);
    import mipsPkg::*;

    localparam logic [dataWidth-2:0] zeroHigh = '0;

    always_comb begin
        case (op)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluAnd:  y = a & b;
            aluOr:   y = a | b;
            aluXor:  y = a ^ b;
            aluNor:  y = ~(a | b);
            aluSlt:  y = {zeroHigh, $signed(a) < $signed(b)};
            aluSltu: y = {zeroHigh, a < b};
            // shifts act on rt
            aluSll:  y = b << shamt;
            aluSrl:  y = b >> shamt;
            aluSra:  y = $unsigned($signed(b) >>> shamt);
            aluLui:  y = {b[15:0], 16'b0};
            default: y = '0;
        endcase
    end
endmodule

`default_nettype wire

/* design/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  mipsPkg::regAddr_t rsD,
    input  mipsPkg::regAddr_t rtD,
    input  mipsPkg::regAddr_t rsE,
    input  mipsPkg::regAddr_t rtE,
    input  mipsPkg::regAddr_t wnumM,
    input  mipsPkg::regAddr_t wnumW,
    input  logic              wenM,
    input  logic              wenW,
    input  logic              memReadE,
    input  logic              branchTakenE,
    output logic              stallF,
    output logic              stallD,
    output logic              flushD,
    output logic              flushE,
    output logic [1:0]        forwardA,
    output logic [1:0]        forwardB
);
    import mipsPkg::*;

    logic loadUse;

    // memory stage holds the younger result so it wins
    function automatic logic [1:0] pickSource(input regAddr_t src);
        if (src == '0) begin
            return fwdNone;
        end else if (wenM && src == wnumM) begin
            return fwdMem;
        end else if (wenW && src == wnumW) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    // lw writes rt
    assign loadUse = memReadE && rtE != '0 && (rtE == rsD || rtE == rtD);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushE = loadUse;        // bubble into execute
    assign flushD = branchTakenE;   // kill wrong-path fetch

    always_comb begin
        forwardA = pickSource(rsE);
        forwardB = pickSource(rtE);
        assert ((forwardA != fwdMem && forwardB != fwdMem) || wenM)
            else $error("forward from memory stage with no write pending");
        assert ((forwardA != fwdWb && forwardB != fwdWb) || wenW)
            else $error("forward from writeback with no write pending");
    end
endmodule

`default_nettype wire

/* design/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  mipsPkg::instrWord_u  instr,
    output mipsPkg::decodeCtrl_t ctrl,
    output logic [31:0]          imm
);
    import mipsPkg::*;

    logic zeroExt;

    // logic immediates are zero extended
    assign zeroExt = instr.iType.opcode inside {opAndi, opOri, opXori};
    assign imm = zeroExt ? {16'b0, instr.iType.imm16}
                         : {{16{instr.iType.imm16[15]}}, instr.iType.imm16};

    always_comb begin
        ctrl = '0;  // anything unknown decodes as a nop
        case (instr.iType.opcode)
            opSpecial: begin
                ctrl.regWrite = 1'b1;
                ctrl.dstSel = dstRd;
                case (instr.rType.funct)
                    functAddu: ctrl.aluOp = aluAdd;
                    functSubu: ctrl.aluOp = aluSub;
                    functAnd:  ctrl.aluOp = aluAnd;
                    functOr:   ctrl.aluOp = aluOr;
                    functXor:  ctrl.aluOp = aluXor;
                    functNor:  ctrl.aluOp = aluNor;
                    functSlt:  ctrl.aluOp = aluSlt;
                    functSltu: ctrl.aluOp = aluSltu;
                    functSll:  ctrl.aluOp = aluSll;
                    functSrl:  ctrl.aluOp = aluSrl;
                    functSra:  ctrl.aluOp = aluSra;
                    functJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.isJr = 1'b1;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opAddiu, opSlti, opAndi, opOri, opXori, opLui: begin
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dstSel = dstRt;
                case (instr.iType.opcode)
                    opSlti:  ctrl.aluOp = aluSlt;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opLw: begin
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dstSel = dstRt;
                ctrl.memRead = 1'b1;
            end
            opSw: begin
                ctrl.useImm = 1'b1;     // address is rs + offset
                ctrl.memWrite = 1'b1;
            end
            opBeq: ctrl.isBranch = 1'b1;
            opBne: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchNe = 1'b1;
            end
            opJ: ctrl.isJump = 1'b1;
            opJal: begin
                ctrl.isJump = 1'b1;
                ctrl.link = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dstSel = dstRa;
            end
            default: ;
        endcase
    end
endmodule

`default_nettype wire

/* design/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter logic [31:0] resetVector = 32'hbfc00000
) (
    input  logic              clk,
    input  logic              rstN,
    output logic [31:0]       pcF,
    input  logic [31:0]       instrF,
    output logic              memEn,
    output logic              memWen,
    output logic [31:0]       memAddr,
    output logic [31:0]       memWdata,
    input  logic [31:0]       memRdata,
    output logic [31:0]       debugWbPc,
    output logic              debugWbRfWen,
    output mipsPkg::regAddr_t debugWbRfWnum,
    output logic [31:0]       debugWbRfWdata
);
    import mipsPkg::*;

    logic stallF, stallD, flushD, flushE, branchTakenE;
    logic [1:0] forwardA, forwardB;
    logic [31:0] pcNext;
    instrWord_u instrD;
    decodeCtrl_t ctrlD, ctrlE, ctrlM;
    logic [31:0] pcD, pcPlus4D, immD, rd1D, rd2D, jumpTargetD;
    logic [31:0] pcE, rd1E, rd2E, immE, rsValE, rtValE, aluBE, aluYE, resultE, targetE;
    regAddr_t rsE, rtE, rdE, wnumE, wnumM;
    logic [4:0] shamtE;
    logic [31:0] pcM, aluOutM, storeDataM, resultM;
    logic wenM;
    commitInfo_t commitW;

    function automatic logic [31:0] fwdMux(input logic [1:0] sel, input logic [31:0] regVal,
                                           input logic [31:0] memVal, input logic [31:0] wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    // redirect from execute outranks the stall
    always_comb begin
        if (branchTakenE) begin
            pcNext = targetE;
        end else if (stallF) begin
            pcNext = pcF;
        end else if (ctrlD.isJump) begin
            pcNext = jumpTargetD;
        end else begin
            pcNext = pcF + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF <= resetVector;
            instrD <= '0;
            ctrlE <= '0;
            ctrlM <= '0;
            commitW <= '0;
        end else begin
            pcF <= pcNext;
            if (flushD) begin
                instrD <= '0;   // all zero is sll r0 so a nop
            end else if (!stallD) begin
                instrD.raw <= instrF;
            end
            ctrlE <= flushE ? '0 : ctrlD;
            ctrlM <= ctrlE;
            commitW <= '{wen: wenM, wnum: wnumM, wdata: resultM, pc: pcM};
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD <= pcF;
        end
        pcE <= pcD;
        rd1E <= rd1D;
        rd2E <= rd2D;
        immE <= immD;
        rsE <= instrD.rType.rs;
        rtE <= instrD.rType.rt;
        rdE <= instrD.rType.rd;
        shamtE <= instrD.rType.shamt;
        pcM <= pcE;
        aluOutM <= resultE;
        storeDataM <= rtValE;
        wnumM <= wnumE;
    end

    instrDecoder instrDecoder_i (
        .instr(instrD),
        .ctrl (ctrlD),
        .imm  (immD)
    );

    regFile regFile_i (
        .clk(clk),
        .ra1(instrD.rType.rs),
        .ra2(instrD.rType.rt),
        .wa (commitW.wnum),
        .we (commitW.wen),
        .wd (commitW.wdata),
        .rd1(rd1D),
        .rd2(rd2D)
    );

    assign pcPlus4D = pcD + 32'd4;
    assign jumpTargetD = {pcPlus4D[31:28], instrD.raw[25:0], 2'b00};

    hazardUnit hazardUnit_i (
        .rsD         (instrD.rType.rs),
        .rtD         (instrD.rType.rt),
        .rsE         (rsE),
        .rtE         (rtE),
        .wnumM       (wnumM),
        .wnumW       (commitW.wnum),
        .wenM        (wenM),
        .wenW        (commitW.wen),
        .memReadE    (ctrlE.memRead),
        .branchTakenE(branchTakenE),
        .stallF      (stallF),
        .stallD      (stallD),
        .flushD      (flushD),
        .flushE      (flushE),
        .forwardA    (forwardA),
        .forwardB    (forwardB)
    );

    assign rsValE = fwdMux(forwardA, rd1E, aluOutM, commitW.wdata);
    assign rtValE = fwdMux(forwardB, rd2E, aluOutM, commitW.wdata);
    assign aluBE = ctrlE.useImm ? immE : rtValE;

    aluUnit aluUnit_i (
        .op   (ctrlE.aluOp),
        .a    (rsValE),
        .b    (aluBE),
        .shamt(shamtE),
        .y    (aluYE)
    );

    assign resultE = ctrlE.link ? pcE + 32'd8 : aluYE;    // return past the delay slot
    assign branchTakenE = ctrlE.isJr | (ctrlE.isBranch & ((rsValE == rtValE) ^ ctrlE.branchNe));
    assign targetE = ctrlE.isJr ? rsValE : pcE + 32'd4 + {immE[29:0], 2'b00};

    always_comb begin
        case (ctrlE.dstSel)
            dstRt:   wnumE = rtE;
            dstRa:   wnumE = linkReg;
            default: wnumE = rdE;
        endcase
    end

    assign wenM = ctrlM.regWrite && wnumM != '0;    // r0 writes never commit
    assign memEn = ctrlM.memRead | ctrlM.memWrite;
    assign memWen = ctrlM.memWrite;
    assign memAddr = aluOutM;
    assign memWdata = storeDataM;
    assign resultM = ctrlM.memRead ? memRdata : aluOutM;

    assign debugWbPc = commitW.pc;
    assign debugWbRfWen = commitW.wen;
    assign debugWbRfWnum = commitW.wnum;
    assign debugWbRfWdata = commitW.wdata;

    storeAligned: assert property (@(posedge clk) disable iff (!rstN)
        memWen |-> memAddr[1:0] == 2'b00);
    flushNotStall: assert property (@(posedge clk) disable iff (!rstN)
        !(flushD && stallD));
endmodule

`default_nettype wire

/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;
    localparam int dataWidth = 32;

    typedef logic [4:0] regAddr_t;

    localparam regAddr_t linkReg = 5'd31;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct field under opSpecial
    localparam logic [5:0] functSll  = 6'h00;
    localparam logic [5:0] functSrl  = 6'h02;
    localparam logic [5:0] functSra  = 6'h03;
    localparam logic [5:0] functJr   = 6'h08;
    localparam logic [5:0] functAddu = 6'h21;
    localparam logic [5:0] functSubu = 6'h23;
    localparam logic [5:0] functAnd  = 6'h24;
    localparam logic [5:0] functOr   = 6'h25;
    localparam logic [5:0] functXor  = 6'h26;
    localparam logic [5:0] functNor  = 6'h27;
    localparam logic [5:0] functSlt  = 6'h2a;
    localparam logic [5:0] functSltu = 6'h2b;

    // destination register select
    localparam logic [1:0] dstRd = 2'd0;
    localparam logic [1:0] dstRt = 2'd1;
    localparam logic [1:0] dstRa = 2'd2;

    // forwarding source select
    localparam logic [1:0] fwdNone = 2'd0;
    localparam logic [1:0] fwdWb   = 2'd1;
    localparam logic [1:0] fwdMem  = 2'd2;

    typedef union packed {
        logic [31:0] raw;       // jump target lives in raw[25:0]
        struct packed {
            logic [5:0] opcode;
            regAddr_t   rs;
            regAddr_t   rt;
            regAddr_t   rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            regAddr_t    rs;
            regAddr_t    rt;
            logic [15:0] imm16;
        } iType;
    } instrWord_u;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOp_e;

    typedef struct packed {
        aluOp_e     aluOp;
        logic       useImm;     // operand b is the immediate
        logic       regWrite;
        logic [1:0] dstSel;
        logic       memRead;
        logic       memWrite;
        logic       isBranch;
        logic       branchNe;
        logic       isJump;
        logic       isJr;
        logic       link;       // write pc+8
    } decodeCtrl_t;

    typedef struct packed {
        logic                 wen;
        regAddr_t             wnum;
        logic [dataWidth-1:0] wdata;
        logic [31:0]          pc;
    } commitInfo_t;
endpackage

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic              clk,
    input  mipsPkg::regAddr_t ra1,
    input  mipsPkg::regAddr_t ra2,
    input  mipsPkg::regAddr_t wa,
    input  logic              we,
    input  logic [31:0]       wd,
    output logic [31:0]       rd1,
    output logic [31:0]       rd2
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regs [32];

    function automatic logic [dataWidth-1:0] readPort(input regAddr_t ra);
        if (ra == '0) begin
            return '0;
        end else if (we && wa == ra) begin
            return wd;  // same-cycle write from writeback
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = readPort(ra1);
        rd2 = readPort(ra2);
    end

    zeroReg: assert property (@(posedge clk)
        (ra1 != '0 || rd1 == '0) && (ra2 != '0 || rd2 == '0));
endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module coreTb -f sources.f -o coreSim \
    && ./obj_dir/coreSim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "TEST FAIL" sim.log \
    && echo "simulation passed" \
    || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

/* sources.f */
+incdir+test
design/mipsPkg.sv
design/instrDecoder.sv
design/regFile.sv
design/aluUnit.sv
design/hazardUnit.sv
design/mipsCore.sv
test/coreTb.sv

/* test/refModel.svh */
// model state stepped one instruction at a time
logic [31:0] modelRegs [32];
logic [31:0] modelMem [64];
logic [31:0] modelPc;
logic [31:0] modelNpc;  // delay slot address

function automatic logic [31:0] rWord(input logic [5:0] funct, input regAddr_t rd, rs, rt,
                                      input logic [4:0] sh);
    return {opSpecial, rs, rt, rd, sh, funct};
endfunction

function automatic logic [31:0] iWord(input logic [5:0] op, input regAddr_t rt, rs,
                                      input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] jWord(input logic [5:0] op, input logic [31:0] target);
    return {op, target[27:2]};
endfunction

function automatic logic [31:0] addrOf(input int idx);
    return progBase + 32'(idx) * 32'd4;
endfunction

task automatic addInstr(input logic [31:0] word);
    imem[progLen] = word;
    progLen++;
endtask

function automatic commitInfo_t refStep(input instrWord_u ins);
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] sImm;
    logic [31:0] zImm;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] target;
    logic [31:0] pcPlus4;
    regAddr_t dst;
    logic wr;
    commitInfo_t info;
    rsVal = modelRegs[ins.rType.rs];
    rtVal = modelRegs[ins.rType.rt];
    sImm = {{16{ins.iType.imm16[15]}}, ins.iType.imm16};
    zImm = {16'b0, ins.iType.imm16};
    addr = rsVal + sImm;
    pcPlus4 = modelPc + 32'd4;
    res = '0;
    dst = ins.iType.rt;
    wr = 1'b1;
    target = modelNpc + 32'd4;    // straight line after the delay slot
    case (ins.iType.opcode)
        opSpecial: begin
            dst = ins.rType.rd;
            case (ins.rType.funct)
                functAddu: res = rsVal + rtVal;
                functSubu: res = rsVal - rtVal;
                functAnd:  res = rsVal & rtVal;
                functOr:   res = rsVal | rtVal;
                functXor:  res = rsVal ^ rtVal;
                functNor:  res = ~(rsVal | rtVal);
                functSlt:  res = {31'b0, $signed(rsVal) < $signed(rtVal)};
                functSltu: res = {31'b0, rsVal < rtVal};
                functSll:  res = rtVal << ins.rType.shamt;
                functSrl:  res = rtVal >> ins.rType.shamt;
                functSra:  res = $signed(rtVal) >>> ins.rType.shamt;
                functJr: begin
                    wr = 1'b0;
                    target = rsVal;
                end
                default: wr = 1'b0;
            endcase
        end
        opAddiu: res = rsVal + sImm;
        opSlti:  res = {31'b0, $signed(rsVal) < $signed(sImm)};
        opAndi:  res = rsVal & zImm;
        opOri:   res = rsVal | zImm;
        opXori:  res = rsVal ^ zImm;
        opLui:   res = {ins.iType.imm16, 16'b0};
        opLw:    res = modelMem[addr[7:2]];
        opSw: begin
            wr = 1'b0;
            modelMem[addr[7:2]] = rtVal;
        end
        opBeq, opBne: begin
            wr = 1'b0;
            if ((rsVal == rtVal) == (ins.iType.opcode == opBeq)) begin
                target = pcPlus4 + (sImm << 2);
            end
        end
        opJ, opJal: begin
            wr = ins.iType.opcode == opJal;
            dst = linkReg;
            res = modelPc + 32'd8;  // past the delay slot
            target = {pcPlus4[31:28], ins.raw[25:0], 2'b00};
        end
        default: wr = 1'b0;
    endcase
    info.wen = wr && dst != '0;
    info.wnum = dst;
    info.wdata = res;
    info.pc = modelPc;
    if (info.wen) begin
        modelRegs[dst] = res;
    end
    modelPc = modelNpc;
    modelNpc = target;
    return info;
endfunction

task automatic buildDirected();
    int base;
    // immediates
    addInstr(iWord(opLui, 1, 0, 16'h1234));
    addInstr(iWord(opOri, 1, 1, 16'h8765));
    addInstr(iWord(opAddiu, 2, 0, 16'hfffb));
    addInstr(iWord(opSlti, 3, 2, 16'hfffa));
    addInstr(iWord(opAndi, 4, 2, 16'hff0f));
    addInstr(iWord(opXori, 5, 1, 16'hffff));
    // dependent chain forwarded from memory and writeback
    addInstr(rWord(functAddu, 7, 1, 2, 0));
    addInstr(rWord(functSubu, 8, 7, 1, 0));
    addInstr(rWord(functAnd, 9, 8, 7, 0));
    addInstr(rWord(functOr, 10, 9, 5, 0));
    addInstr(rWord(functXor, 11, 10, 9, 0));
    addInstr(rWord(functNor, 12, 11, 0, 0));
    addInstr(rWord(functSlt, 13, 12, 11, 0));
    addInstr(rWord(functSltu, 14, 11, 12, 0));
    addInstr(rWord(functSll, 15, 0, 14, 5));
    addInstr(rWord(functSra, 16, 0, 2, 2));
    addInstr(rWord(functSrl, 17, 0, 12, 3));
    // loads and stores with several load-use pairs
    addInstr(iWord(opSw, 1, 0, 16'h0000));
    addInstr(iWord(opSw, 12, 0, 16'h0004));
    addInstr(iWord(opLw, 20, 0, 16'h0000));
    addInstr(rWord(functAddu, 21, 20, 20, 0));
    addInstr(iWord(opLw, 22, 0, 16'h0004));
    addInstr(iWord(opSw, 22, 0, 16'h0008));
    addInstr(iWord(opLw, 23, 0, 16'h000c));
    addInstr(rWord(functXor, 24, 23, 22, 0));
    addInstr(iWord(opSw, 24, 0, 16'h0010));
    // offset 2 skips one word past the delay slot
    addInstr(iWord(opAddiu, 1, 0, 16'h0003));
    addInstr(iWord(opAddiu, 2, 0, 16'h0003));
    addInstr(iWord(opBeq, 2, 1, 16'h0002));
    addInstr(iWord(opAddiu, 3, 0, 16'h000b));
    addInstr(iWord(opAddiu, 4, 0, 16'h0063));
    addInstr(iWord(opBne, 2, 1, 16'h0002));
    addInstr(iWord(opAddiu, 5, 0, 16'h000c));
    addInstr(iWord(opAddiu, 6, 0, 16'h000d));
    addInstr(iWord(opLw, 7, 0, 16'h0000));
    addInstr(iWord(opBne, 0, 7, 16'h0002));
    addInstr(iWord(opAddiu, 8, 0, 16'h000e));
    addInstr(iWord(opAddiu, 9, 0, 16'h0063));
    addInstr(iWord(opBeq, 8, 1, 16'h0002));
    addInstr(iWord(opAddiu, 10, 0, 16'h000f));
    addInstr(iWord(opAddiu, 11, 0, 16'h0010));
    // jal to a subroutine at base+7, jr back, j over two words
    base = progLen;
    addInstr(jWord(opJal, addrOf(base + 7)));
    addInstr(iWord(opAddiu, 16, 0, 16'h0015));
    addInstr(rWord(functAddu, 17, 31, 0, 0));
    addInstr(jWord(opJ, addrOf(base + 10)));
    addInstr(iWord(opAddiu, 18, 0, 16'h0016));
    addInstr(iWord(opAddiu, 19, 0, 16'h0063));
    addInstr(iWord(opAddiu, 20, 0, 16'h0063));
    addInstr(iWord(opAddiu, 21, 0, 16'h0017));
    addInstr(rWord(functJr, 0, 31, 0, 0));
    addInstr(iWord(opAddiu, 22, 0, 16'h0018));
    addInstr(iWord(opAddiu, 23, 0, 16'h0019));
endtask

task automatic buildRandom();
    logic [5:0] rFuncts [11] = '{functAddu, functSubu, functAnd, functOr, functXor, functNor,
                                 functSlt, functSltu, functSll, functSrl, functSra};
    logic [5:0] iOps [5] = '{opAddiu, opSlti, opAndi, opOri, opXori};
    logic [31:0] r;
    logic [31:0] v;
    int kind;
    regAddr_t rd;
    regAddr_t rs;
    regAddr_t rt;
    for (int k = 1; k < 8; k++) begin   // known start values in r1..r7
        v = $random(seed);
        addInstr(iWord(opLui, regAddr_t'(k), 5'd0, v[31:16]));
        addInstr(iWord(opOri, regAddr_t'(k), regAddr_t'(k), v[15:0]));
    end
    for (int i = 0; i < 40; i++) begin
        r = $random(seed);
        v = $random(seed);
        kind = int'(r[7:0] % 8'd17);
        rd = regAddr_t'(r[15:8] % 8'd7 + 8'd1);
        rs = regAddr_t'(r[23:16] % 8'd7 + 8'd1);
        rt = regAddr_t'(r[31:24] % 8'd7 + 8'd1);
        if (kind < 8) begin
            addInstr(rWord(rFuncts[kind], rd, rs, rt, 5'd0));
        end else if (kind < 11) begin
            addInstr(rWord(rFuncts[kind], rd, 5'd0, rt, v[20:16]));  // shifts
        end else if (kind < 16) begin
            addInstr(iWord(iOps[kind - 11], rd, rs, v[15:0]));
        end else begin
            addInstr(iWord(opLui, rd, 5'd0, v[15:0]));
        end
    end
endtask

/* test/coreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTb;
    import mipsPkg::*;

    localparam logic [31:0] progBase = 32'h0001_0000;
    localparam int imemDepth = 256;

    logic clk = 1'b0;
    logic rstN;
    logic [31:0] pcF;
    logic [31:0] instrF;
    logic memEn;
    logic memWen;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] memRdata;
    logic [31:0] debugWbPc;
    logic debugWbRfWen;
    regAddr_t debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    logic [31:0] imem [imemDepth];
    logic [31:0] dmem [64];
    logic [31:0] fetchIdx;
    int progLen;
    integer seed;
    int errors;
    int commits;
    int memWords;
    commitInfo_t expected [$];

    `include "refModel.svh"

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ 32'h5a5ac3c3;
    endfunction

    always #20 clk = ~clk;

    mipsCore #(
        .resetVector(progBase)
    ) mipsCore_i (
        .clk           (clk),
        .rstN          (rstN),
        .pcF           (pcF),
        .instrF        (instrF),
        .memEn         (memEn),
        .memWen        (memWen),
        .memAddr       (memAddr),
        .memWdata      (memWdata),
        .memRdata      (memRdata),
        .debugWbPc     (debugWbPc),
        .debugWbRfWen  (debugWbRfWen),
        .debugWbRfWnum (debugWbRfWnum),
        .debugWbRfWdata(debugWbRfWdata)
    );

    // both memories read combinationally
    assign fetchIdx = (pcF - progBase) >> 2;
    assign instrF = (fetchIdx < imemDepth) ? imem[fetchIdx[7:0]] : 32'h0;
    assign memRdata = memEn ? dmem[memAddr[7:2]] : 32'h0;  // data port idle without enable

    always @(posedge clk) begin
        if (memEn && memWen) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    task automatic predictCommits();
        commitInfo_t info;
        modelPc = progBase;
        modelNpc = progBase + 32'd4;
        while (modelPc - progBase < 32'(progLen) * 32'd4) begin
            info = refStep(imem[(modelPc - progBase) >> 2]);
            if (info.wen) begin
                expected.push_back(info);
            end
        end
    endtask

    task automatic checkCommit();
        commitInfo_t exp;
        if (expected.size() == 0) begin
            $display("unexpected commit to r%0d from pc %h after the last expected commit",
                     debugWbRfWnum, debugWbPc);
            errors++;
        end else begin
            exp = expected.pop_front();
            commits++;
            if (debugWbPc !== exp.pc || debugWbRfWnum !== exp.wnum
                    || debugWbRfWdata !== exp.wdata) begin
                $display("FAILED at %0t: commit pc %h r%0d = %h, expected pc %h r%0d = %h",
                         $time, debugWbPc, debugWbRfWnum, debugWbRfWdata,
                         exp.pc, exp.wnum, exp.wdata);
                errors++;
            end
        end
    endtask

    task automatic checkMemory();
        for (int i = 0; i < 64; i++) begin
            memWords++;
            if (dmem[i] !== modelMem[i]) begin
                $display("FAILED at %0t: data word at %h is %h, expected %h",
                         $time, 32'(i) * 32'd4, dmem[i], modelMem[i]);
                errors++;
            end
        end
    endtask

    // commit stream compare
    always @(posedge clk) begin
        if (rstN && debugWbRfWen) begin
            checkCommit();
        end
    end

    initial begin
        rstN = 1'b0;
        seed = 32'h913e;
        errors = 0;
        commits = 0;
        memWords = 0;
        progLen = 0;
        for (int i = 0; i < imemDepth; i++) begin
            imem[i] = '0;   // sll r0 past the program end
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(32'(i) * 32'd4);
            modelMem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        buildDirected();
        buildRandom();
        addInstr(iWord(opAddiu, 25, 0, 16'h007e));  // last commit
        predictCommits();
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);  // catch stray commits
        checkMemory();
        $display("commits checked: %0d, memory words checked: %0d, errors: %0d",
                 commits, memWords, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog allows four cycles per instruction plus margin
    initial begin
        @(posedge rstN);
        repeat (progLen * 4 + 50) @(posedge clk);
        $display("final commit never arrived, %0d expected commits still outstanding",
                 expected.size());
        $display("TEST FAIL");
        $finish;
    end
endmodule

`default_nettype wire
